/* fifo16ch_top.f */
+incdir+include
rtl/fifo16ch_pkg.sv
rtl/sync_fifo.sv
rtl/chan_fifo_bank.sv
rtl/fifo_load_fsm.sv
rtl/evt_overlap_tracker.sv
rtl/l1a_trig_ctrl.sv
rtl/fifo16ch_top.sv
sim/fifo16ch_props.sv
sim/fifo16ch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert \
	-f fifo16ch_top.f --top-module fifo16ch_tb &&
./obj_dir/Vfifo16ch_tb | tee /dev/stderr | grep -qx "Test passed" &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

/* sim/fifo16ch_tb.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module fifo16ch_tb;

	import fifo16ch_pkg::*;

	localparam int NUM_BURSTS  = 12;
	localparam int MAX_EVT     = 4;     // Matches per burst at most
	localparam int SMP_CYC     = 12;    // WRCLK cycles per sample clock period
	localparam int TICK_CYC    = 8;     // Tick cycle, 3 after the falling edge
	localparam int WATCHDOG_NS = (NUM_BURSTS * MAX_EVT * 20 + 40) * SMP_CYC * 8;

	logic                          WRCLK;
	logic                          RST_RESYNC;
	logic                          l1a_i;
	logic                          l1a_match_i;
	logic                          smp_clk_i;
	logic [`FIFO16_SMP_W-1:0]      samp_max_i;
	grp_word_t                     grp_i [`FIFO16_GROUPS];
	logic [`FIFO16_CH-1:0]         rd_ena_i;
	logic                          hdr_rd_en_i;
	grp_word_t                     dout_o;
	logic [`FIFO16_CH-1:0]         fmt_o;
	logic                          rdy_o;
	smp_hdr_t                      hdr_o;
	logic [`FIFO16_L1A_CNT_W-1:0]  l1a_cnt_o;
	logic [`FIFO16_MTCH_CNT_W-1:0] l1a_mtch_cnt_o;

	integer                        seed;

	// Reference model
	int unsigned                   m_remain;   // Samples left in the run
	bit [`FIFO16_PIPE_LEN-1:0]     m_starts;   // Bit k set if an event began k+1 ticks ago
	int unsigned                   m_ovlp;
	int unsigned                   m_l1a;
	int unsigned                   m_mtch;
	bit                            m_phase;    // Phase captured at the previous match
	grp_word_t                     exp_rows [$];
	smp_hdr_t                      exp_hdrs [$];

	fifo16ch_top u_dut (
		.WRCLK          (WRCLK),
		.RST_RESYNC     (RST_RESYNC),
		.l1a_i          (l1a_i),
		.l1a_match_i    (l1a_match_i),
		.smp_clk_i      (smp_clk_i),
		.samp_max_i     (samp_max_i),
		.grp_i          (grp_i),
		.rd_ena_i       (rd_ena_i),
		.hdr_rd_en_i    (hdr_rd_en_i),
		.dout_o         (dout_o),
		.fmt_o          (fmt_o),
		.rdy_o          (rdy_o),
		.hdr_o          (hdr_o),
		.l1a_cnt_o      (l1a_cnt_o),
		.l1a_mtch_cnt_o (l1a_mtch_cnt_o)
	);

	initial begin
		WRCLK = 1'b0;
		forever #4 WRCLK = ~WRCLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the simulation did not complete within the expected time");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Model of one sample tick
	////////////////////////////////////////////////////////////
	task automatic model_tick(input bit match);
		int unsigned nxt;
		bit          oinc;
		bit          evt_end;
		bit          odec;
		smp_hdr_t    hdr;
		oinc = match && (m_remain != 0);            // New match during a run
		if (match)
			nxt = 32'(samp_max_i) + 1;
		else if (m_remain != 0)
			nxt = m_remain - 1;
		else
			nxt = 0;
		if (nxt != 0) begin
			evt_end        = m_starts[samp_max_i - 1'b1];
			hdr            = '0;                     // No match two cycles before a tick
			hdr.evt_end    = evt_end;
			hdr.ovrlap     = (m_ovlp > 0);
			hdr.multi_ovlp = (m_ovlp > 1);
			hdr.l1a_phase  = m_phase;
			hdr.ovrlp_cnt  = 4'(m_ovlp);
			hdr.l1amcnt    = 12'(m_mtch);            // Count before this match
			hdr.l1acnt     = 24'(m_l1a);
			exp_hdrs.push_back(hdr);
			for (int g = 0; g < `FIFO16_GROUPS; g++)
				exp_rows.push_back(grp_i[g]);
			odec = evt_end && (m_ovlp > 0 || oinc);
			if (oinc && !odec)
				m_ovlp = m_ovlp + 1;
			else if (odec && !oinc)
				m_ovlp = m_ovlp - 1;
			m_starts = {m_starts[`FIFO16_PIPE_LEN-2:0], match};
		end else begin
			m_ovlp   = 0;                            // Idle clears overlap and pipe
			m_starts = '0;
		end
		m_remain = nxt;
		if (match)
			m_phase = (TICK_CYC >= SMP_CYC / 2);     // Sample clock low at the match
	endtask

	// One full sample clock period, high half first
	task automatic drive_sample_period(input bit match);
		bit l1a;
		l1a = ($random(seed) % 2) != 0;
		if (l1a)
			m_l1a = m_l1a + 1;
		model_tick(match);
		if (match)
			m_mtch = m_mtch + 1;
		for (int c = 0; c < SMP_CYC; c++) begin
			@(posedge WRCLK);
			smp_clk_i   <= (c < SMP_CYC / 2);
			l1a_i       <= l1a && (c == 2);
			l1a_match_i <= match && (c == TICK_CYC);   // Lands in the tick cycle
		end
		@(negedge WRCLK);
		compare_value(64'(l1a_cnt_o), 64'(m_l1a), "trigger counter");
		compare_value(64'(l1a_mtch_cnt_o), 64'(m_mtch), "match counter");
	endtask

	////////////////////////////////////////////////////////////
	// Drain channel and header FIFOs against the model
	////////////////////////////////////////////////////////////
	task automatic drain_and_check();
		grp_word_t row;
		smp_hdr_t  hdr;
		compare_value(64'(rdy_o), 64'(exp_hdrs.size() != 0), "rdy_o before reads");
		while (exp_rows.size() != 0) begin
			row = exp_rows.pop_front();
			@(negedge WRCLK);
			compare_value(64'(fmt_o), 64'(0), "fmt_o with data pending");
			for (int ch = 0; ch < `FIFO16_CH; ch++)
				compare_value(64'(dout_o[ch]), 64'(row[ch]), $sformatf("channel %0d word", ch));
			@(posedge WRCLK);
			rd_ena_i <= '1;
			@(posedge WRCLK);
			rd_ena_i <= '0;
		end
		@(negedge WRCLK);
		compare_value(64'(fmt_o), 64'({`FIFO16_CH{1'b1}}), "fmt_o after drain");
		while (exp_hdrs.size() != 0) begin
			hdr = exp_hdrs.pop_front();
			@(negedge WRCLK);
			compare_value(64'(rdy_o), 64'(1), "rdy_o with headers pending");
			compare_value(64'(hdr_o.evt_end), 64'(hdr.evt_end), "header evt_end");
			compare_value(64'(hdr_o.ovrlap), 64'(hdr.ovrlap), "header ovrlap");
			compare_value(64'(hdr_o.multi_ovlp), 64'(hdr.multi_ovlp), "header multi_ovlp");
			compare_value(64'(hdr_o.l1a_phase), 64'(hdr.l1a_phase), "header l1a_phase");
			compare_value(64'(hdr_o.l1a_match), 64'(hdr.l1a_match), "header l1a_match");
			compare_value(64'(hdr_o.ovrlp_cnt), 64'(hdr.ovrlp_cnt), "header ovrlp_cnt");
			compare_value(64'(hdr_o.l1amcnt), 64'(hdr.l1amcnt), "header l1amcnt");
			compare_value(64'(hdr_o.l1acnt), 64'(hdr.l1acnt), "header l1acnt");
			@(posedge WRCLK);
			hdr_rd_en_i <= 1'b1;
			@(posedge WRCLK);
			hdr_rd_en_i <= 1'b0;
		end
		@(negedge WRCLK);
		compare_value(64'(rdy_o), 64'(0), "rdy_o after last header");
	endtask

	// New group data and run length while idle, then matches until the run ends
	task automatic run_burst();
		int p;
		@(posedge WRCLK);
		for (int g = 0; g < `FIFO16_GROUPS; g++)
			for (int ch = 0; ch < `FIFO16_CH; ch++)
				grp_i[g][ch] <= chan_word_t'($random(seed));
		samp_max_i <= 7'(1 + ($unsigned($random(seed)) % 6));
		@(negedge WRCLK);                           // Model sees the new inputs
		drive_sample_period(1'b1);
		p = 1;
		while (m_remain != 0) begin
			drive_sample_period(p < MAX_EVT && ($random(seed) % 2) != 0);
			p = p + 1;
		end
		drain_and_check();
	endtask

	initial begin
		seed        = 32'ha14839c2;
		RST_RESYNC  = 1'b1;
		l1a_i       = 1'b0;
		l1a_match_i = 1'b0;
		smp_clk_i   = 1'b0;
		samp_max_i  = 7'd1;
		rd_ena_i    = '0;
		hdr_rd_en_i = 1'b0;
		for (int g = 0; g < `FIFO16_GROUPS; g++)
			grp_i[g] = '0;
		m_remain = 0;
		m_starts = '0;
		m_ovlp   = 0;
		m_l1a    = 0;
		m_mtch   = 0;
		m_phase  = 1'b0;
		repeat (16) @(posedge WRCLK);
		RST_RESYNC <= 1'b0;
		@(negedge WRCLK);
		compare_value(64'(fmt_o), 64'({`FIFO16_CH{1'b1}}), "fmt_o after reset");
		compare_value(64'(rdy_o), 64'(0), "rdy_o after reset");
		compare_value(64'(l1a_cnt_o), 64'(0), "trigger counter after reset");
		compare_value(64'(l1a_mtch_cnt_o), 64'(0), "match counter after reset");
		for (int b = 0; b < NUM_BURSTS; b++)
			run_burst();
		$display("Test passed");
		$finish;
	end

endmodule

/* sim/fifo16ch_props.sv */
`timescale 1ns/1ps

module fifo16ch_props (
	input logic       WRCLK,
	input logic       RST_RESYNC,
	input logic       run_i,
	input logic       wren_i,
	input logic [2:0] sel_i,
	input logic       rdy_i,
	input logic       hdr_wr_i
);

	// Channel writes only inside a run
	a_wren_in_run: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC) wren_i |-> run_i
	) else $error("channel write strobe active while no run is active");

	a_sel_range: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC) wren_i |-> (sel_i < 3'd6)
	) else $error("group select out of range during a channel write");

	// Header FIFO holds data right after a header write
	a_rdy_after_write: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC) hdr_wr_i |=> rdy_i
	) else $error("rdy_o low in the cycle after a header write");

	a_rdy_rise: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC) $rose(rdy_i) |-> $past(hdr_wr_i)
	) else $error("rdy_o rose without a header write");

endmodule

bind fifo16ch_top fifo16ch_props u_props (
	.WRCLK       (WRCLK),
	.RST_RESYNC  (RST_RESYNC),
	.run_i       (run),
	.wren_i      (wren),
	.sel_i       (sel),
	.rdy_i       (rdy_o),
	.hdr_wr_i    (hdr_wr)
);

/* rtl/fifo16ch_top.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module fifo16ch_top (
	input  logic                          WRCLK,
	input  logic                          RST_RESYNC,
	input  logic                          l1a_i,
	input  logic                          l1a_match_i,
	input  logic                          smp_clk_i,
	input  logic [`FIFO16_SMP_W-1:0]      samp_max_i,
	input  fifo16ch_pkg::grp_word_t       grp_i [`FIFO16_GROUPS],
	input  logic [`FIFO16_CH-1:0]         rd_ena_i,
	input  logic                          hdr_rd_en_i,
	output fifo16ch_pkg::grp_word_t       dout_o,
	output logic [`FIFO16_CH-1:0]         fmt_o,
	output logic                          rdy_o,
	output fifo16ch_pkg::smp_hdr_t        hdr_o,
	output logic [`FIFO16_L1A_CNT_W-1:0]  l1a_cnt_o,
	output logic [`FIFO16_MTCH_CNT_W-1:0] l1a_mtch_cnt_o
);

	import fifo16ch_pkg::*;

	trig_state_t                   trig;
	smp_hdr_t                      hdr_din;
	logic                          run;
	logic                          wren;
	logic [2:0]                    sel;
	logic                          evt_end;
	logic                          ovrlap;
	logic                          multi_ovlp;
	logic [`FIFO16_OVLP_CNT_W-1:0] ovrlp_cnt;
	logic                          hdr_wr;
	logic                          hdr_empty;

	////////////////////////////////////////////////////////////
	// Trigger, overlap and load control
	////////////////////////////////////////////////////////////
	l1a_trig_ctrl u_trig (
		.WRCLK          (WRCLK),
		.RST_RESYNC     (RST_RESYNC),
		.l1a_i          (l1a_i),
		.l1a_match_i    (l1a_match_i),
		.smp_clk_i      (smp_clk_i),
		.run_i          (run),
		.trig_o         (trig),
		.l1a_cnt_o      (l1a_cnt_o),
		.l1a_mtch_cnt_o (l1a_mtch_cnt_o)
	);

	evt_overlap_tracker u_ovlp (
		.WRCLK        (WRCLK),
		.trig_i       (trig),
		.run_i        (run),
		.samp_max_i   (samp_max_i),
		.evt_end_o    (evt_end),
		.ovrlap_o     (ovrlap),
		.multi_ovlp_o (multi_ovlp),
		.ovrlp_cnt_o  (ovrlp_cnt)
	);

	fifo_load_fsm u_load (
		.WRCLK      (WRCLK),
		.RST_RESYNC (RST_RESYNC),
		.trig_i     (trig),
		.samp_max_i (samp_max_i),
		.run_o      (run),
		.wren_o     (wren),
		.sel_o      (sel)
	);

	////////////////////////////////////////////////////////////
	// Data and header storage
	////////////////////////////////////////////////////////////
	chan_fifo_bank u_bank (
		.WRCLK      (WRCLK),
		.RST_RESYNC (RST_RESYNC),
		.grp_i      (grp_i),
		.sel_i      (sel),
		.wren_i     (wren),
		.rd_ena_i   (rd_ena_i),
		.dout_o     (dout_o),
		.fmt_o      (fmt_o)
	);

	always_comb begin
		hdr_din.evt_end    = evt_end;
		hdr_din.multi_ovlp = multi_ovlp;
		hdr_din.ovrlap     = ovrlap;
		hdr_din.l1a_phase  = trig.l1a_phase_r1;
		hdr_din.l1a_match  = trig.l1a_match_d2;
		hdr_din.ovrlp_cnt  = ovrlp_cnt;
		hdr_din.l1amcnt    = trig.l1amcnt_r1;
		hdr_din.l1acnt     = trig.l1acnt_r1;
	end

	assign hdr_wr = trig.smp_tick & run;   // One header per sample
	assign rdy_o  = ~hdr_empty;

	sync_fifo #(
		.WIDTH      ($bits(smp_hdr_t)),
		.DEPTH_LOG2 (`FIFO16_HDR_DEPTH_LOG2)
	) u_hdr_fifo (
		.WRCLK      (WRCLK),
		.RST_RESYNC (RST_RESYNC),
		.wr_en_i    (hdr_wr),
		.din_i      (hdr_din),
		.rd_en_i    (hdr_rd_en_i),
		.dout_o     (hdr_o),
		.empty_o    (hdr_empty),
		.full_o     ()
	);

endmodule

/* rtl/l1a_trig_ctrl.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module l1a_trig_ctrl (
	input  logic                          WRCLK,
	input  logic                          RST_RESYNC,
	input  logic                          l1a_i,
	input  logic                          l1a_match_i,
	input  logic                          smp_clk_i,
	input  logic                          run_i,
	output fifo16ch_pkg::trig_state_t     trig_o,
	output logic [`FIFO16_L1A_CNT_W-1:0]  l1a_cnt_o,
	output logic [`FIFO16_MTCH_CNT_W-1:0] l1a_mtch_cnt_o
);

	logic [`FIFO16_L1A_CNT_W-1:0]  l1acnt;
	logic [`FIFO16_L1A_CNT_W-1:0]  l1acnt_r1;
	logic [`FIFO16_MTCH_CNT_W-1:0] l1amcnt;
	logic [`FIFO16_MTCH_CNT_W-1:0] l1amcnt_r1;
	logic                          l1a_match_d1;
	logic                          l1a_match_d2;
	logic                          l1a_phase;
	logic                          l1a_phase_r1;
	logic                          smpclk_d1;
	logic                          smpclk_d2;
	logic                          smpclk_d3;
	logic                          run_d1;
	logic                          new_l1a;
	logic                          new_l1a_d1;
	logic                          stretch_l1a;
	logic                          smp_tick;

	////////////////////////////////////////////////////////////
	// Trigger and match counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			l1acnt  <= '0;
			l1amcnt <= '0;
		end else begin
			if (l1a_i)
				l1acnt <= l1acnt + 1'b1;
			if (l1a_match_i)
				l1amcnt <= l1amcnt + 1'b1;
		end
	end

	// Sample clock chain, match delays and run history
	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			smpclk_d1    <= 1'b0;
			smpclk_d2    <= 1'b0;
			smpclk_d3    <= 1'b0;
			l1a_match_d1 <= 1'b0;
			l1a_match_d2 <= 1'b0;
			new_l1a_d1   <= 1'b0;
			run_d1       <= 1'b0;
		end else begin
			smpclk_d1    <= smp_clk_i;
			smpclk_d2    <= smpclk_d1;
			smpclk_d3    <= smpclk_d2;
			l1a_match_d1 <= l1a_match_i;
			l1a_match_d2 <= l1a_match_d1;
			new_l1a_d1   <= new_l1a;
			run_d1       <= run_i;       // Run level before this cycle's tick
		end
	end

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			l1a_phase    <= 1'b0;
			l1a_phase_r1 <= 1'b0;
		end else begin
			if (l1a_match_i)
				l1a_phase <= ~smp_clk_i;     // Match landed in low half
			l1a_phase_r1 <= l1a_phase;
		end
		l1acnt_r1  <= l1acnt;
		l1amcnt_r1 <= l1amcnt;
	end

	assign smp_tick    = smpclk_d3 & ~smpclk_d2;
	assign stretch_l1a = l1a_match_i | l1a_match_d1;
	assign new_l1a     = l1a_match_i & run_d1;

	always_comb begin
		trig_o.smp_tick     = smp_tick;
		trig_o.evt_start    = stretch_l1a & smp_tick;
		trig_o.oinc         = new_l1a | new_l1a_d1 | (l1a_match_i & l1a_match_d1);
		trig_o.l1a_match_d2 = l1a_match_d2;
		trig_o.l1a_phase_r1 = l1a_phase_r1;
		trig_o.l1acnt_r1    = l1acnt_r1;
		trig_o.l1amcnt_r1   = l1amcnt_r1;
	end

	assign l1a_cnt_o      = l1acnt;
	assign l1a_mtch_cnt_o = l1amcnt;

endmodule

/* rtl/evt_overlap_tracker.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module evt_overlap_tracker (
	input  logic                          WRCLK,
	input  fifo16ch_pkg::trig_state_t     trig_i,
	input  logic                          run_i,
	input  logic [`FIFO16_SMP_W-1:0]      samp_max_i,
	output logic                          evt_end_o,
	output logic                          ovrlap_o,
	output logic                          multi_ovlp_o,
	output logic [`FIFO16_OVLP_CNT_W-1:0] ovrlp_cnt_o
);

	logic [`FIFO16_PIPE_LEN-2:0]   evt_pipe;
	logic [`FIFO16_PIPE_LEN-1:0]   evt_taps;
	logic [`FIFO16_OVLP_CNT_W-1:0] ovrlp_cnt;
	logic                          odec;

	////////////////////////////////////////////////////////////
	// Event pipe, one stage per sample tick
	////////////////////////////////////////////////////////////
	assign evt_taps  = {evt_pipe, trig_i.evt_start};   // Tap 0 is the start tick itself
	assign evt_end_o = evt_taps[samp_max_i];

	always_ff @(posedge WRCLK) begin
		if (!run_i)
			evt_pipe <= '0;
		else if (trig_i.smp_tick)
			evt_pipe <= evt_taps[`FIFO16_PIPE_LEN-2:0];
	end

	////////////////////////////////////////////////////////////
	// Overlap counter
	////////////////////////////////////////////////////////////
	assign odec = evt_end_o & (ovrlap_o | trig_i.oinc);

	always_ff @(posedge WRCLK) begin
		if (!run_i) begin
			ovrlp_cnt <= '0;
		end else if (trig_i.smp_tick) begin
			case ({trig_i.oinc, odec})
				2'b10:   ovrlp_cnt <= ovrlp_cnt + 1'b1;
				2'b01:   ovrlp_cnt <= ovrlp_cnt - 1'b1;
				default: ovrlp_cnt <= ovrlp_cnt;   // Start and end cancel
			endcase
		end
	end

	assign ovrlap_o     = (ovrlp_cnt > 0);
	assign multi_ovlp_o = (ovrlp_cnt > 1);
	assign ovrlp_cnt_o  = ovrlp_cnt;

endmodule

/* rtl/fifo_load_fsm.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module fifo_load_fsm (
	input  logic                      WRCLK,
	input  logic                      RST_RESYNC,
	input  fifo16ch_pkg::trig_state_t trig_i,
	input  logic [`FIFO16_SMP_W-1:0]  samp_max_i,
	output logic                      run_o,
	output logic                      wren_o,
	output logic [2:0]                sel_o
);

	localparam logic [2:0] LAST_SEL = 3'(`FIFO16_GROUPS - 1);

	logic [`FIFO16_SMP_W:0] smp_cnt;
	logic [`FIFO16_SMP_W:0] smp_cnt_nxt;
	logic [2:0]             sel_q;
	logic                   wren_q;

	// Remaining samples, reloaded by every new event
	always_comb begin
		smp_cnt_nxt = smp_cnt;
		if (trig_i.smp_tick) begin
			if (trig_i.evt_start)
				smp_cnt_nxt = {1'b0, samp_max_i} + 1'b1;
			else if (smp_cnt != '0)
				smp_cnt_nxt = smp_cnt - 1'b1;
		end
	end

	assign run_o = (smp_cnt_nxt != '0);   // Covers the start tick

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			smp_cnt <= '0;
			sel_q   <= '0;
			wren_q  <= 1'b0;
		end else begin
			smp_cnt <= smp_cnt_nxt;
			if (trig_i.smp_tick && run_o) begin
				sel_q  <= '0;                // New sample, group 1 first
				wren_q <= 1'b1;
			end else if (wren_q) begin
				if (sel_q == LAST_SEL)
					wren_q <= 1'b0;          // Hold sel until next tick
				else
					sel_q <= sel_q + 1'b1;
			end
		end
	end

	assign wren_o = wren_q;
	assign sel_o  = sel_q;

endmodule

/* rtl/chan_fifo_bank.sv */
`timescale 1ns/1ps
`include "fifo16ch_params.svh"

module chan_fifo_bank (
	input  logic                    WRCLK,
	input  logic                    RST_RESYNC,
	input  fifo16ch_pkg::grp_word_t grp_i [`FIFO16_GROUPS],
	input  logic [2:0]              sel_i,
	input  logic                    wren_i,
	input  logic [`FIFO16_CH-1:0]   rd_ena_i,
	output fifo16ch_pkg::grp_word_t dout_o,
	output logic [`FIFO16_CH-1:0]   fmt_o
);

	import fifo16ch_pkg::*;

	grp_word_t mux_word;

	// Group select
	always_comb begin
		if (sel_i < 3'(`FIFO16_GROUPS))
			mux_word = grp_i[sel_i];
		else
			mux_word = '0;
	end

	////////////////////////////////////////////////////////////
	// One FIFO per channel, all written together
	////////////////////////////////////////////////////////////
	for (genvar ch = 0; ch < `FIFO16_CH; ch = ch + 1) begin : g_chan
		sync_fifo #(
			.WIDTH      (`FIFO16_CH_W),
			.DEPTH_LOG2 (`FIFO16_CH_DEPTH_LOG2)
		) u_fifo (
			.WRCLK      (WRCLK),
			.RST_RESYNC (RST_RESYNC),
			.wr_en_i    (wren_i),
			.din_i      (mux_word[ch]),
			.rd_en_i    (rd_ena_i[ch]),
			.dout_o     (dout_o[ch]),
			.empty_o    (fmt_o[ch]),
			.full_o     ()
		);
	end

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH      = 12,
	parameter int DEPTH_LOG2 = 10
) (
	input  logic             WRCLK,
	input  logic             RST_RESYNC,
	input  logic             wr_en_i,
	input  logic [WIDTH-1:0] din_i,
	input  logic             rd_en_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;
	logic                do_wr;
	logic                do_rd;

	// Extra pointer bit tells full from empty
	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
		(wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

	assign do_wr = wr_en_i & ~full_o;    // Write when full is lost
	assign do_rd = rd_en_i & ~empty_o;

	assign dout_o = mem[rd_ptr[DEPTH_LOG2-1:0]];   // Head word visible

	always_ff @(posedge WRCLK) begin
		if (do_wr)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= din_i;
	end

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

/* rtl/fifo16ch_pkg.sv */
`include "fifo16ch_params.svh"

package fifo16ch_pkg;

	typedef logic [`FIFO16_CH_W-1:0] chan_word_t;

	typedef chan_word_t [`FIFO16_CH-1:0] grp_word_t;   // Channel 0 in low bits

	////////////////////////////////////////////////////////////
	// Per-sample header, 45 bits
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                          evt_end;      // Last sample of an event
		logic                          multi_ovlp;
		logic                          ovrlap;
		logic                          l1a_phase;
		logic                          l1a_match;
		logic [`FIFO16_OVLP_CNT_W-1:0] ovrlp_cnt;
		logic [`FIFO16_MTCH_CNT_W-1:0] l1amcnt;
		logic [`FIFO16_L1A_CNT_W-1:0]  l1acnt;
	} smp_hdr_t;

	////////////////////////////////////////////////////////////
	// Trigger state shared by the overlap and load blocks
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                          smp_tick;     // Falling phase of sample clock
		logic                          evt_start;
		logic                          oinc;         // Overlap increment request
		logic                          l1a_match_d2;
		logic                          l1a_phase_r1;
		logic [`FIFO16_L1A_CNT_W-1:0]  l1acnt_r1;
		logic [`FIFO16_MTCH_CNT_W-1:0] l1amcnt_r1;
	} trig_state_t;

endpackage

/* include/fifo16ch_params.svh */
`ifndef FIFO16CH_PARAMS_SVH
`define FIFO16CH_PARAMS_SVH

// Channel and group geometry
`define FIFO16_CH              16
`define FIFO16_GROUPS          6
`define FIFO16_CH_W            12

// Samples per event minus one, and the event pipe behind it
`define FIFO16_SMP_W           7
`define FIFO16_PIPE_LEN        128

// Counter widths
`define FIFO16_L1A_CNT_W       24
`define FIFO16_MTCH_CNT_W      12
`define FIFO16_OVLP_CNT_W      4

// FIFO depths as powers of two
`define FIFO16_CH_DEPTH_LOG2   10
`define FIFO16_HDR_DEPTH_LOG2  8

`endif
